/* compile.f */
+incdir+include
src/rob_pkg.sv
src/rob_walk_if.sv
src/rob_entry.sv
src/rob_src_lookup.sv
src/rob_restore_walk.sv
src/rob.sv
verif/rob_assertions.sv
verif/rob_tb.sv

/* Bender.yml */
package:
  name: rob

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - src/rob_pkg.sv
      - src/rob_walk_if.sv
      - src/rob_entry.sv
      - src/rob_src_lookup.sv
      - src/rob_restore_walk.sv
      - src/rob.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/rob_assertions.sv
      - verif/rob_tb.sv

/* verif/rob_tb.sv */
`include "rob_settings.svh"

module rob_tb import rob_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int ID_W = ROB_IDX_W + 1;
   localparam int NUM = `ROB_NUM_ENTS;
   // Longest run is the random mix plus its drain, far below this
   localparam int MAX_CYCLES = 3000;

   typedef struct {
      logic [ID_W-1:0]            robid;
      logic                       dv;
      logic [`ROB_REG_ADDR_W-1:0] dreg;
      logic [`ROB_PRF_ID_W-1:0]   prf;
      bit                         done;
      bit                         flush;
      bit                         mis;
   } rec_t;

   logic clk;
   logic reset;
   logic alloc;
   logic alloc_dst_valid;
   logic [`ROB_REG_ADDR_W-1:0] alloc_dst_reg;
   logic [`ROB_PRF_ID_W-1:0] alloc_pdst_old;
   logic rob_ready;
   t_rob_id oldest_robid;
   t_rob_id next_robid;
   logic result_valid;
   t_rob_id result_robid;
   logic result_flush;
   logic result_mispred;
   logic [`ROB_REG_ADDR_W-1:0] src_addr [`ROB_NUM_SOURCES];
   logic src_pending [`ROB_NUM_SOURCES];
   t_rob_id src_robid [`ROB_NUM_SOURCES];
   logic retire_valid;
   t_rob_id retire_robid;
   logic reclaim_valid;
   logic [`ROB_PRF_ID_W-1:0] reclaim_prfid;
   logic nuke_valid;
   t_nuke_type nuke_type;
   logic restore_valid;
   logic [`ROB_REG_ADDR_W-1:0] restore_gpr;
   logic [`ROB_PRF_ID_W-1:0] restore_prfid;
   logic resume_fetch;

   // Reference model of the buffer and the restore walk
   rec_t q[$];
   rec_t walk_q[$];
   logic [ID_W-1:0] model_head;
   logic [ID_W-1:0] model_tail;
   int wait_cnt;
   bit resume_due;
   int errors;
   int checks;
   int nuke_cnt;
   int resume_cnt;
   int cycles;
   logic [31:0] seed;

   rob rob_i (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("FAILED %s got %h expected %h", name, got, exp);
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic bit walker_busy();
      return (wait_cnt > 0) || (walk_q.size() > 0) || resume_due;
   endfunction

   function automatic bit expect_ready();
      return (q.size() < NUM) && !walker_busy();
   endfunction

   function automatic bit head_flushing();
      return (q.size() > 0) && q[0].flush;
   endfunction

   function automatic int first_undone();
      for (int i = 0; i < q.size(); i++) begin
         if (!q[i].done) return i;
      end
      return -1;
   endfunction

   // Checks one cycle against the model, then moves to the next falling edge
   task automatic step();
      rec_t r;
      bit exp_ret;
      bit exp_nuke;
      bit exp_ready;
      bit hit;
      logic [ID_W-1:0] hit_id;
      #1;
      exp_ready = expect_ready();
      check("rob_ready", rob_ready, exp_ready);
      check("oldest_robid", oldest_robid, model_head);
      check("next_robid", next_robid, model_tail);
      for (int s = 0; s < `ROB_NUM_SOURCES; s++) begin
         hit = 1'b0;
         hit_id = '0;
         for (int i = q.size() - 1; i >= 0; i--) begin
            if (!hit && q[i].dv && q[i].dreg == src_addr[s]) begin
               hit = 1'b1;
               hit_id = q[i].robid;
            end
         end
         check("src_pending", src_pending[s], hit);
         if (hit) check("src_robid", src_robid[s], hit_id);
      end
      // Restore side
      if (resume_fetch) resume_cnt++;
      if (wait_cnt > 0) begin
         check("restore_valid", restore_valid, 0);
         check("resume_fetch", resume_fetch, 0);
         wait_cnt--;
      end else if (walk_q.size() > 0) begin
         r = walk_q.pop_front();
         check("restore_valid", restore_valid, r.dv);
         check("resume_fetch", resume_fetch, 0);
         if (r.dv) begin
            check("restore_gpr", restore_gpr, r.dreg);
            check("restore_prfid", restore_prfid, r.prf);
         end
      end else begin
         check("restore_valid", restore_valid, 0);
         check("resume_fetch", resume_fetch, resume_due);
         resume_due = 1'b0;
      end
      // Head of the buffer
      exp_nuke = head_flushing();
      exp_ret = (q.size() > 0) && q[0].done && !q[0].flush;
      if (nuke_valid) nuke_cnt++;
      check("nuke_valid", nuke_valid, exp_nuke);
      check("retire_valid", retire_valid, exp_ret);
      check("reclaim_valid", reclaim_valid, exp_ret && q[0].dv);
      if (exp_nuke) check("nuke_type", nuke_type, q[0].mis);
      if (exp_ret) begin
         check("retire_robid", retire_robid, q[0].robid);
         if (q[0].dv) check("reclaim_prfid", reclaim_prfid, q[0].prf);
         void'(q.pop_front());
         model_head++;
      end
      if (result_valid) begin
         for (int i = 0; i < q.size(); i++) begin
            if (q[i].robid == result_robid) begin
               r = q[i];
               r.done = 1'b1;
               r.flush = result_flush;
               r.mis = result_mispred;
               q[i] = r;
            end
         end
      end
      if (exp_nuke) begin
         // Walk visits every flushed entry, youngest first
         for (int i = q.size() - 1; i >= 0; i--) walk_q.push_back(q[i]);
         q.delete();
         model_tail = model_head;
         wait_cnt = `ROB_QUIESCE_CYCLES;
         resume_due = 1'b1;
      end else if (alloc && exp_ready) begin
         r = '{model_tail, alloc_dst_valid, alloc_dst_reg, alloc_pdst_old, 0, 0, 0};
         q.push_back(r);
         model_tail++;
      end
      @(negedge clk);
      alloc = 1'b0;
      result_valid = 1'b0;
   endtask

   task automatic alloc_one(input logic dv, input int dreg, input int prf);
      while (!rob_ready) step();
      alloc = 1'b1;
      alloc_dst_valid = dv;
      alloc_dst_reg = dreg[`ROB_REG_ADDR_W-1:0];
      alloc_pdst_old = prf[`ROB_PRF_ID_W-1:0];
      step();
   endtask

   task automatic send_result(input logic [ID_W-1:0] id, input logic flush, input logic mis);
      result_valid = 1'b1;
      result_robid = id;
      result_flush = flush;
      result_mispred = mis;
      step();
   endtask

   // Completes the oldest open entry each cycle until empty and idle
   task automatic drain();
      int k;
      while (q.size() > 0 || walker_busy()) begin
         k = first_undone();
         if (k >= 0) begin
            result_valid = 1'b1;
            result_robid = q[k].robid;
            result_flush = 1'b0;
            result_mispred = 1'b0;
         end
         step();
      end
   endtask

   task automatic fill_test();
      for (int i = 0; i < NUM; i++) alloc_one(i[0], i + 1, 40 + i);
      step();
      check("rob_ready when full", rob_ready, 0);
   endtask

   task automatic retire_order_test();
      int ord[NUM];
      logic [ID_W-1:0] base;
      ord = '{3, 0, 5, 1, 7, 2, 6, 4};
      // Offsets count from the head before anything retires
      base = model_head;
      for (int i = 0; i < NUM; i++) send_result(base + ord[i], 1'b0, 1'b0);
      drain();
   endtask

   task automatic lookup_test();
      int dests[7];
      dests = '{3, 7, 3, 9, 5, 7, 3};
      for (int i = 0; i < 5; i++) alloc_one(1'b1, i + 1, i);
      drain();
      // These entries straddle the index wrap
      for (int i = 0; i < 7; i++) alloc_one(i != 4, dests[i], 20 + i);
      for (int r = 0; r < 12; r++) begin
         src_addr[0] = r[`ROB_REG_ADDR_W-1:0];
         src_addr[1] = `ROB_REG_ADDR_W'(11 - r);
         step();
      end
      drain();
   endtask

   task automatic flush_test(input logic mis);
      int n0;
      int r0;
      n0 = nuke_cnt;
      r0 = resume_cnt;
      for (int i = 0; i < 5; i++) alloc_one(i != 1, 10 + i, 30 + i);
      send_result(q[2].robid, 1'b0, 1'b0);
      send_result(q[3].robid, 1'b0, 1'b0);
      send_result(q[0].robid, 1'b1, mis);
      while (q.size() > 0 || walker_busy()) step();
      step();
      check("nuke pulses", nuke_cnt - n0, 1);
      check("resume pulses", resume_cnt - r0, 1);
      check("rob_ready after restore", rob_ready, 1);
      check("empty after restore", oldest_robid == next_robid, 1);
   endtask

   task automatic random_test();
      logic [31:0] r;
      int k;
      for (int n = 0; n < 300; n++) begin
         seed = xorshift32(seed);
         r = seed;
         src_addr[0] = r[29:25];
         src_addr[1] = r[4:0];
         if (r[0] && expect_ready() && !head_flushing()) begin
            alloc = 1'b1;
            alloc_dst_valid = r[1];
            alloc_dst_reg = r[6:2];
            alloc_pdst_old = r[12:7];
         end
         if (r[13] && q.size() > 0) begin
            k = int'(r[20:16]) % q.size();
            if (!q[k].done) begin
               result_valid = 1'b1;
               result_robid = q[k].robid;
               result_flush = (r[23:21] == 3'd0);
               result_mispred = r[24];
            end
         end
         step();
      end
      drain();
   endtask

   initial begin
      reset = 1'b1;
      alloc = 1'b0;
      alloc_dst_valid = 1'b0;
      alloc_dst_reg = '0;
      alloc_pdst_old = '0;
      result_valid = 1'b0;
      result_robid = '0;
      result_flush = 1'b0;
      result_mispred = 1'b0;
      for (int s = 0; s < `ROB_NUM_SOURCES; s++) src_addr[s] = '0;
      model_head = '0;
      model_tail = '0;
      wait_cnt = 0;
      resume_due = 1'b0;
      errors = 0;
      checks = 0;
      nuke_cnt = 0;
      resume_cnt = 0;
      seed = 32'hdffe;
      repeat (8) @(negedge clk);
      reset = 1'b0;
      step();
      fill_test();
      retire_order_test();
      lookup_test();
      flush_test(1'b0);
      flush_test(1'b1);
      random_test();
      // Failures of the bound assertions count as errors too
      errors += rob_i.rob_assertions_i.fail_cnt;
      $display("Run finished with %0d errors in %0d checks", errors, checks);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout, run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks failed");
      $finish;
   end

endmodule

/* verif/rob_assertions.sv */
`include "rob_settings.svh"

module rob_assertions import rob_pkg::*; (
   input logic                   clk,
   input logic                   reset,
   input logic                   alloc,
   input logic                   rob_ready,
   input logic                   retire_valid,
   input logic [ROB_IDX_W:0]     retire_robid,
   input logic                   nuke_valid,
   input logic                   restore_valid,
   input logic                   resume_fetch,
   input logic                   walk_active
);

   timeunit 1ns;
   timeprecision 100ps;

   logic [ROB_IDX_W:0] last_retired;
   logic               retired_once;

   // Number of assertion failures so far
   int                 fail_cnt = 0;

   // Robid of the previous retirement, wrap bit included
   always_ff @(posedge clk) begin
      if (reset) begin
         retired_once <= 1'b0;
         last_retired <= '0;
      end else if (retire_valid) begin
         retired_once <= 1'b1;
         last_retired <= retire_robid;
      end
   end

   assert property (@(posedge clk) disable iff (reset) alloc |-> rob_ready)
      else begin
         fail_cnt++;
         $error("alloc seen while rob_ready is low");
      end

   assert property (@(posedge clk) disable iff (reset)
                    retire_valid && retired_once |-> retire_robid == last_retired + 1'b1)
      else begin
         fail_cnt++;
         $error("retire_robid did not advance by one");
      end

   assert property (@(posedge clk) disable iff (reset) !(nuke_valid && retire_valid))
      else begin
         fail_cnt++;
         $error("nuke_valid and retire_valid high together");
      end

   // Resume comes right after the last walk cycle, never with a restore
   assert property (@(posedge clk) disable iff (reset)
                    resume_fetch |-> !restore_valid && $past(walk_active))
      else begin
         fail_cnt++;
         $error("resume_fetch not one state after the restore walk");
      end

endmodule

bind rob rob_assertions rob_assertions_i (
   .clk           (clk),
   .reset         (reset),
   .alloc         (alloc),
   .rob_ready     (rob_ready),
   .retire_valid  (retire_valid),
   .retire_robid  (retire_robid),
   .nuke_valid    (nuke_valid),
   .restore_valid (restore_valid),
   .resume_fetch  (resume_fetch),
   .walk_active   (walk_if.walk_active)
);

/* src/rob.sv */
`include "rob_settings.svh"

module rob import rob_pkg::*; (
   input  logic                       clk,
   input  logic                       reset,

   // Alloc
   input  logic                       alloc,
   input  logic                       alloc_dst_valid,
   input  logic [`ROB_REG_ADDR_W-1:0] alloc_dst_reg,
   input  logic [`ROB_PRF_ID_W-1:0]   alloc_pdst_old,
   output logic                       rob_ready,
   output t_rob_id                    oldest_robid,
   output t_rob_id                    next_robid,

   // Completion
   input  logic                       result_valid,
   input  t_rob_id                    result_robid,
   input  logic                       result_flush,
   input  logic                       result_mispred,

   // Rename source lookup
   input  logic [`ROB_REG_ADDR_W-1:0] src_addr    [`ROB_NUM_SOURCES],
   output logic                       src_pending [`ROB_NUM_SOURCES],
   output t_rob_id                    src_robid   [`ROB_NUM_SOURCES],

   // Retire and reclaim
   output logic                       retire_valid,
   output t_rob_id                    retire_robid,
   output logic                       reclaim_valid,
   output logic [`ROB_PRF_ID_W-1:0]   reclaim_prfid,

   // Nuke and rename table restore
   output logic                       nuke_valid,
   output t_nuke_type                 nuke_type,
   output logic                       restore_valid,
   output logic [`ROB_REG_ADDR_W-1:0] restore_gpr,
   output logic [`ROB_PRF_ID_W-1:0]   restore_prfid,
   output logic                       resume_fetch
);

   t_rob_id                  head_id;
   t_rob_id                  tail_id;
   logic                     rob_empty;
   logic                     rob_full;
   logic                     alloc_fire;
   logic [`ROB_NUM_ENTS-1:0] alloc_oh;
   logic [`ROB_NUM_ENTS-1:0] retire_oh;
   t_rob_static              alloc_static;
   t_rob_ent                 entries [`ROB_NUM_ENTS];
   t_rob_ent                 head_ent;
   t_rob_ent                 walk_ent;

   rob_walk_if walk_if ();

   // Pointers
   always_ff @(posedge clk) begin
      if (reset) begin
         head_id <= '0;
      end else if (retire_valid) begin
         head_id <= incr_robid(head_id);
      end
   end

   // A nuke drops everything younger than the head, so the tail snaps back
   always_ff @(posedge clk) begin
      if (reset) begin
         tail_id <= '0;
      end else if (nuke_valid) begin
         tail_id <= head_id;
      end else if (alloc_fire) begin
         tail_id <= incr_robid(tail_id);
      end
   end

   assign rob_empty    = (head_id == tail_id);
   assign rob_full     = (head_id.idx == tail_id.idx) & (head_id.wrap != tail_id.wrap);
   assign rob_ready    = ~rob_full & ~walk_if.busy;
   assign oldest_robid = head_id;
   assign next_robid   = tail_id;

   // Alloc
   assign alloc_fire   = alloc & rob_ready;
   assign alloc_oh     = {{(`ROB_NUM_ENTS-1){1'b0}}, alloc_fire} << tail_id.idx;
   assign alloc_static = '{dst_valid: alloc_dst_valid,
                           dst_reg:   alloc_dst_reg,
                           pdst_old:  alloc_pdst_old};

   // Retire and nuke from the head entry
   assign head_ent      = entries[head_id.idx];
   assign retire_valid  = ~rob_empty & head_ent.valid & head_ent.done & ~head_ent.flush_needed;
   assign retire_oh     = {{(`ROB_NUM_ENTS-1){1'b0}}, retire_valid} << head_id.idx;
   assign retire_robid  = head_id;
   assign reclaim_valid = retire_valid & head_ent.s.dst_valid;
   assign reclaim_prfid = head_ent.s.pdst_old;

   assign nuke_valid = ~rob_empty & head_ent.valid & head_ent.flush_needed;
   assign nuke_type  = head_ent.mispred ? NUKE_BR_MISPRED : NUKE_EXCEPTION;

   for (genvar i = 0; i < `ROB_NUM_ENTS; i++) begin : g_ents
      t_rob_id ent_robid;

      // Slots below the head index are on the next lap
      assign ent_robid = '{wrap: (ROB_IDX_W'(i) < head_id.idx) ? ~head_id.wrap : head_id.wrap,
                           idx:  ROB_IDX_W'(i)};

      rob_entry ent_i (
         .clk            (clk),
         .reset          (reset),
         .robid          (ent_robid),
         .alloc_en       (alloc_oh[i]),
         .alloc_static   (alloc_static),
         .result_valid   (result_valid),
         .result_robid   (result_robid),
         .result_flush   (result_flush),
         .result_mispred (result_mispred),
         .flush_now      (nuke_valid),
         .retire_en      (retire_oh[i]),
         .ent            (entries[i])
      );
   end

   rob_src_lookup lookup_i (
      .entries     (entries),
      .head_id     (head_id),
      .tail_id     (tail_id),
      .src_addr    (src_addr),
      .src_pending (src_pending),
      .src_robid   (src_robid)
   );

   // Restore walk
   assign walk_if.flush_now  = nuke_valid;
   assign walk_if.flush_tail = tail_id;
   assign walk_if.head_id    = head_id;

   rob_restore_walk walk_i (
      .clk          (clk),
      .reset        (reset),
      .walk         (walk_if.walker),
      .resume_fetch (resume_fetch)
   );

   // Walker reads the static fields left behind by the flushed entries
   assign walk_ent      = entries[walk_if.walk_robid.idx];
   assign restore_valid = walk_if.walk_active & walk_ent.s.dst_valid;
   assign restore_gpr   = walk_ent.s.dst_reg;
   assign restore_prfid = walk_ent.s.pdst_old;

endmodule

/* src/rob_restore_walk.sv */
`include "rob_settings.svh"

module rob_restore_walk import rob_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   rob_walk_if.walker walk,
   output logic       resume_fetch
);

   localparam int QC_W = $clog2(`ROB_QUIESCE_CYCLES) + 1;

   t_restore_state  state;
   t_restore_state  state_nxt;
   logic [QC_W-1:0] quiet_cnt;
   t_rob_id         walk_robid;
   logic            start;

   // A nuke is only taken from idle, the buffer is empty while busy anyway
   assign start = (state == RR_IDLE) & walk.flush_now;

   always_comb begin
      state_nxt = state;
      case (state)
         RR_IDLE: begin
            if (walk.flush_now) state_nxt = RR_QUIET;
         end
         RR_QUIET: begin
            if (quiet_cnt == '0) state_nxt = RR_WALK;
         end
         RR_WALK: begin
            // Head entry is the last one restored
            if (walk_robid == walk.head_id) state_nxt = RR_RESUME;
         end
         RR_RESUME: begin
            state_nxt = RR_IDLE;
         end
         default: begin
            state_nxt = RR_IDLE;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= RR_IDLE;
      end else begin
         state <= state_nxt;
      end
   end

   // Quiet counter, loaded so RR_QUIET lasts exactly the quiesce length
   always_ff @(posedge clk) begin
      if (reset) begin
         quiet_cnt <= '0;
      end else if (start) begin
         quiet_cnt <= QC_W'(`ROB_QUIESCE_CYCLES - 1);
      end else if (state == RR_QUIET && quiet_cnt != '0) begin
         quiet_cnt <= quiet_cnt - 1'b1;
      end
   end

   // Walk pointer starts at the youngest entry, one below the tail at the nuke
   always_ff @(posedge clk) begin
      if (reset) begin
         walk_robid <= '0;
      end else if (start) begin
         walk_robid <= decr_robid(walk.flush_tail);
      end else if (state == RR_WALK) begin
         walk_robid <= decr_robid(walk_robid);
      end
   end

   assign walk.walk_robid  = walk_robid;
   assign walk.walk_active = (state == RR_WALK);
   assign walk.busy        = (state != RR_IDLE);
   assign resume_fetch     = (state == RR_RESUME);

endmodule

/* src/rob_src_lookup.sv */
`include "rob_settings.svh"

module rob_src_lookup import rob_pkg::*; (
   input  t_rob_ent                   entries     [`ROB_NUM_ENTS],
   input  t_rob_id                    head_id,
   input  t_rob_id                    tail_id,
   input  logic [`ROB_REG_ADDR_W-1:0] src_addr    [`ROB_NUM_SOURCES],
   output logic                       src_pending [`ROB_NUM_SOURCES],
   output t_rob_id                    src_robid   [`ROB_NUM_SOURCES]
);

   for (genvar s = 0; s < `ROB_NUM_SOURCES; s++) begin : g_src
      logic [`ROB_NUM_ENTS-1:0] match;

      for (genvar e = 0; e < `ROB_NUM_ENTS; e++) begin : g_match
         assign match[e] = entries[e].valid & entries[e].s.dst_valid &
                           (entries[e].s.dst_reg == src_addr[s]);
      end

      always_comb begin
         logic [ROB_IDX_W-1:0] pos;
         logic [ROB_IDX_W-1:0] hit_idx;
         logic                 found;
         found   = 1'b0;
         hit_idx = '0;
         // Youngest first, starting just below the tail
         // Last step lands on the tail slot itself, which is the head when full
         for (int k = 1; k <= `ROB_NUM_ENTS; k++) begin
            pos = tail_id.idx - ROB_IDX_W'(k);
            if (!found && match[pos]) begin
               found   = 1'b1;
               hit_idx = pos;
            end
         end
         src_pending[s]    = found;
         src_robid[s].idx  = hit_idx;
         // Slots below the head index are on the next lap
         src_robid[s].wrap = (hit_idx >= head_id.idx) ? head_id.wrap : ~head_id.wrap;
      end
   end

endmodule

/* src/rob_entry.sv */
module rob_entry import rob_pkg::*; (
   input  logic        clk,
   input  logic        reset,

   input  t_rob_id     robid,

   input  logic        alloc_en,
   input  t_rob_static alloc_static,

   input  logic        result_valid,
   input  t_rob_id     result_robid,
   input  logic        result_flush,
   input  logic        result_mispred,

   input  logic        flush_now,
   input  logic        retire_en,

   output t_rob_ent    ent
);

   logic result_hit;

   // Full robid compare, a result for a stale lap never lands here
   assign result_hit = result_valid & ent.valid & (result_robid == robid);

   always_ff @(posedge clk) begin
      if (reset) begin
         ent.valid        <= 1'b0;
         ent.done         <= 1'b0;
         ent.flush_needed <= 1'b0;
         ent.mispred      <= 1'b0;
      end else if (flush_now) begin
         ent.valid <= 1'b0;
      end else if (alloc_en) begin
         ent.valid        <= 1'b1;
         ent.done         <= 1'b0;
         ent.flush_needed <= 1'b0;
         ent.mispred      <= 1'b0;
      end else begin
         if (result_hit) begin
            ent.done         <= 1'b1;
            ent.flush_needed <= result_flush;
            ent.mispred      <= result_mispred;
         end
         if (retire_en) begin
            ent.valid <= 1'b0;
         end
      end
   end

   // Static fields stay put after invalidation, the restore walk reads them
   always_ff @(posedge clk) begin
      if (alloc_en && !flush_now) begin
         ent.s <= alloc_static;
      end
   end

endmodule

/* src/rob_walk_if.sv */
interface rob_walk_if import rob_pkg::*; ();

   // Buffer side
   logic    flush_now;
   t_rob_id flush_tail;
   t_rob_id head_id;

   // Walker side
   logic    walk_active;
   t_rob_id walk_robid;
   logic    busy;

   modport buffer (
      output flush_now, flush_tail, head_id,
      input  walk_active, walk_robid, busy
   );

   modport walker (
      input  flush_now, flush_tail, head_id,
      output walk_active, walk_robid, busy
   );

endinterface

/* src/rob_pkg.sv */
`include "rob_settings.svh"

package rob_pkg;

   localparam int ROB_IDX_W = $clog2(`ROB_NUM_ENTS);

   // Index plus lap bit, so head == tail is empty and same index with
   // different lap is full
   typedef struct packed {
      logic                 wrap;
      logic [ROB_IDX_W-1:0] idx;
   } t_rob_id;

   // Fields written at alloc
   typedef struct packed {
      logic                       dst_valid;
      logic [`ROB_REG_ADDR_W-1:0] dst_reg;
      logic [`ROB_PRF_ID_W-1:0]   pdst_old;
   } t_rob_static;

   typedef struct packed {
      logic        valid;
      logic        done;
      logic        flush_needed;
      logic        mispred;
      t_rob_static s;
   } t_rob_ent;

   typedef enum logic {
      NUKE_EXCEPTION,
      NUKE_BR_MISPRED
   } t_nuke_type;

   typedef enum logic [1:0] {
      RR_IDLE,
      RR_QUIET,
      RR_WALK,
      RR_RESUME
   } t_restore_state;

   function automatic t_rob_id incr_robid(input t_rob_id id);
      t_rob_id nxt;
      nxt.idx  = id.idx + 1'b1;
      // Lap bit flips when the index rolls over to zero
      nxt.wrap = (nxt.idx == '0) ? ~id.wrap : id.wrap;
      return nxt;
   endfunction

   function automatic t_rob_id decr_robid(input t_rob_id id);
      t_rob_id nxt;
      nxt.idx  = id.idx - 1'b1;
      nxt.wrap = (id.idx == '0) ? ~id.wrap : id.wrap;
      return nxt;
   endfunction

endpackage

/* include/rob_settings.svh */
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// Number of buffer entries
// Must be a power of two so the robid index wraps naturally
`define ROB_NUM_ENTS 8

// Rename sources looked up per cycle
`define ROB_NUM_SOURCES 2

// Architectural register address width
`define ROB_REG_ADDR_W 5

// Physical register id width
`define ROB_PRF_ID_W 6

// Quiet period between the nuke and the start of the restore walk
// Gives the rest of the core time to drain before the rename table
// is rewound
`define ROB_QUIESCE_CYCLES 5

`endif
